//--- verilog/dcache_cfg.svh
// data cache geometry
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address and data word
`define DC_ADDR_W 17
`define DC_DATA_W 32

// direct-mapped, one word per line
`define DC_INDEX_W 4
`define DC_OFFSET_W 2
`define DC_LINES 16

// bytes in one line
`define DC_LINE_BYTES (1 << `DC_OFFSET_W)

// tag is what is left above index and offset
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

//--- verilog/dcache_pkg.sv
// data cache types
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_DATA_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    // one bit per byte of the line pair, lowest address in the msb
    typedef logic [2*`DC_LINE_BYTES-1:0] be_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } op_e;

    typedef enum logic [2:0] {
        IDLE,
        FILL_LO,
        FILL_HI,
        READ_OUT,
        STORE_WAIT
    } ctrl_state_e;

    typedef struct packed {
        logic  valid;
        op_e   op;
        size_e size;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_resp_t;

    // wdata holds memory-order bytes from the top
    typedef struct packed {
        logic  valid;
        logic  write;
        size_e size;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

//--- verilog/dcache_storage.sv
// data cache line storage
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_storage (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire dcache_pkg::addr_t        lookup_addr,
    input  wire dcache_pkg::size_e        size,
    output logic                          hit,
    output dcache_pkg::word_t             line_lo,
    output dcache_pkg::word_t             line_hi,
    input  wire logic                     fill_en,
    input  wire dcache_pkg::addr_t        fill_addr,
    input  wire dcache_pkg::word_t        fill_data,
    input  wire logic                     store_en,
    input  wire dcache_pkg::word_t [1:0]  store_bytes,
    input  wire dcache_pkg::be_t          store_mask
);

    logic [`DC_LINES-1:0] valid;
    dcache_pkg::tag_t     tag_arr  [`DC_LINES];
    dcache_pkg::word_t    data_arr [`DC_LINES];

    dcache_pkg::addr_t    next_addr;
    dcache_pkg::index_t   idx_lo;
    dcache_pkg::index_t   idx_hi;
    dcache_pkg::tag_t     tag_lo;
    dcache_pkg::tag_t     tag_hi;
    dcache_pkg::offset_t  offset;
    dcache_pkg::index_t   fill_idx;
    dcache_pkg::tag_t     fill_tag;
    logic                 match_lo;
    logic                 match_hi;

    // next line from the address plus one line, so 15 wraps to 0 with tag + 1
    assign next_addr = lookup_addr + dcache_pkg::addr_t'(`DC_LINE_BYTES);

    assign offset = lookup_addr[`DC_OFFSET_W-1:0];
    assign idx_lo = lookup_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag_lo = lookup_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign idx_hi = next_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag_hi = next_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    assign fill_idx = fill_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign fill_tag = fill_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    assign match_lo = valid[idx_lo] && (tag_arr[idx_lo] == tag_lo);
    assign match_hi = valid[idx_hi] && (tag_arr[idx_hi] == tag_hi);

    assign line_lo = data_arr[idx_lo];
    assign line_hi = data_arr[idx_hi];

    // second line only needed when the access runs past the end of the first
    always_comb begin
        case (size)
            dcache_pkg::SIZE_BYTE: begin
                hit = match_lo;
            end
            dcache_pkg::SIZE_HALF: begin
                hit = match_lo && ((offset != dcache_pkg::offset_t'(3)) || match_hi);
            end
            dcache_pkg::SIZE_WORD: begin
                hit = match_lo && ((offset == '0) || match_hi);
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    // upper mask half is the first line and the lower half the next
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_arr[fill_idx]  <= fill_tag;
            data_arr[fill_idx] <= fill_data;
        end
        if (store_en) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (store_mask[`DC_LINE_BYTES + b] && match_lo) begin
                    data_arr[idx_lo][8*b +: 8] <= store_bytes[0][8*b +: 8];
                end
                if (store_mask[b] && match_hi) begin
                    data_arr[idx_hi][8*b +: 8] <= store_bytes[1][8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_align.sv
// byte lane aligner
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_align (
    input  wire dcache_pkg::offset_t      offset,
    input  wire dcache_pkg::size_e        size,
    input  wire dcache_pkg::word_t        line_lo,
    input  wire dcache_pkg::word_t        line_hi,
    output dcache_pkg::word_t             load_data,
    input  wire dcache_pkg::word_t        store_value,
    output dcache_pkg::word_t [1:0]       store_bytes,
    output dcache_pkg::be_t               store_mask
);

    logic [2*`DC_DATA_W-1:0]   load_pair;
    dcache_pkg::word_t         load_mo;
    dcache_pkg::word_t         load_val;
    dcache_pkg::word_t         store_mo;
    logic [2*`DC_DATA_W-1:0]   store_pair;
    logic [`DC_LINE_BYTES-1:0] size_mask;

    // memory order and value order are byte reversals of each other
    function automatic dcache_pkg::word_t swap_bytes(input dcache_pkg::word_t w);
        dcache_pkg::word_t r;
        for (int b = 0; b < `DC_LINE_BYTES; b++) begin
            r[8*b +: 8] = w[`DC_DATA_W-8-8*b +: 8];
        end
        return r;
    endfunction

    // addressed byte moves to the top of the pair
    assign load_pair = {line_lo, line_hi} << (8 * offset);
    assign load_mo   = load_pair[2*`DC_DATA_W-1 -: `DC_DATA_W];
    assign load_val  = swap_bytes(load_mo);

    always_comb begin
        case (size)
            dcache_pkg::SIZE_BYTE: begin
                load_data = {{24{load_val[7]}}, load_val[7:0]};
                size_mask = 4'b1000;
            end
            dcache_pkg::SIZE_HALF: begin
                load_data = {{16{load_val[15]}}, load_val[15:0]};
                size_mask = 4'b1100;
            end
            default: begin
                load_data = load_val;
                size_mask = 4'b1111;
            end
        endcase
    end

    // low value byte lands at the top, i.e. at the lowest address
    assign store_mo   = swap_bytes(store_value);
    assign store_pair = {store_mo, {`DC_DATA_W{1'b0}}} >> (8 * offset);

    assign store_bytes[0] = store_pair[2*`DC_DATA_W-1 -: `DC_DATA_W];
    assign store_bytes[1] = store_pair[`DC_DATA_W-1:0];
    assign store_mask     = {size_mask, {`DC_LINE_BYTES{1'b0}}} >> offset;

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
// data cache controller
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire dcache_pkg::cpu_req_t     cpu_req,
    output logic                          cpu_ready,
    output dcache_pkg::cpu_resp_t         cpu_resp,
    output dcache_pkg::mem_req_t          mem_req,
    input  wire dcache_pkg::mem_resp_t    mem_resp,
    input  wire logic                     hit,
    input  wire dcache_pkg::word_t        load_data,
    input  wire dcache_pkg::word_t [1:0]  store_bytes,
    output dcache_pkg::addr_t             lookup_addr,
    output dcache_pkg::size_e             size,
    output logic                          fill_en,
    output dcache_pkg::addr_t             fill_addr,
    output dcache_pkg::word_t             fill_data,
    output logic                          store_en
);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::addr_t       req_addr;
    dcache_pkg::size_e       req_size;
    logic                    hi_sent;
    logic                    accept;
    dcache_pkg::addr_t       req_line;
    dcache_pkg::addr_t       next_line;
    dcache_pkg::addr_t       cpu_line;
    logic [2*`DC_DATA_W-1:0] store_pair;
    dcache_pkg::word_t       store_word;

    assign accept = (state == dcache_pkg::IDLE) && cpu_ready && cpu_req.valid;

    // lookup follows the bus while idle, the held request otherwise
    assign lookup_addr = (state == dcache_pkg::IDLE) ? cpu_req.addr : req_addr;
    assign size        = (state == dcache_pkg::IDLE) ? cpu_req.size : req_size;

    // hit bytes are merged on the acceptance edge
    assign store_en = accept && (cpu_req.op == dcache_pkg::OP_STORE);

    assign cpu_line  = {cpu_req.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign req_line  = {req_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign next_line = req_line + dcache_pkg::addr_t'(`DC_LINE_BYTES);

    // undo the offset shift to get the bytes back to the top of the word
    assign store_pair = {store_bytes[0], store_bytes[1]} << (8 * cpu_req.addr[`DC_OFFSET_W-1:0]);
    assign store_word = store_pair[2*`DC_DATA_W-1 -: `DC_DATA_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= dcache_pkg::IDLE;
            cpu_ready     <= 1'b1;
            cpu_resp.done <= 1'b0;
            mem_req.valid <= 1'b0;
            fill_en       <= 1'b0;
            hi_sent       <= 1'b0;
        end else begin
            cpu_resp.done <= 1'b0;
            fill_en       <= 1'b0;
            case (state)
                dcache_pkg::IDLE: begin
                    if (accept) begin
                        cpu_ready <= 1'b0;
                        req_addr  <= cpu_req.addr;
                        req_size  <= cpu_req.size;
                        hi_sent   <= 1'b0;
                        if (cpu_req.op == dcache_pkg::OP_STORE) begin
                            mem_req <= '{valid: 1'b1, write: 1'b1, size: cpu_req.size,
                                         addr: cpu_req.addr, wdata: store_word};
                            state   <= dcache_pkg::STORE_WAIT;
                        end else if (hit) begin
                            cpu_resp.done  <= 1'b1;
                            cpu_resp.rdata <= load_data;
                        end else begin
                            mem_req <= '{valid: 1'b1, write: 1'b0, size: dcache_pkg::SIZE_WORD,
                                         addr: cpu_line, wdata: '0};
                            state   <= dcache_pkg::FILL_LO;
                        end
                    end else begin
                        cpu_ready <= 1'b1;
                    end
                end
                dcache_pkg::FILL_LO: begin
                    if (mem_resp.done) begin
                        fill_en       <= 1'b1;
                        fill_addr     <= req_line;
                        fill_data     <= mem_resp.rdata;
                        mem_req.valid <= 1'b0;
                        state         <= dcache_pkg::FILL_HI;
                    end
                end
                dcache_pkg::FILL_HI: begin
                    if (mem_req.valid) begin
                        if (mem_resp.done) begin
                            fill_en       <= 1'b1;
                            fill_addr     <= next_line;
                            fill_data     <= mem_resp.rdata;
                            mem_req.valid <= 1'b0;
                        end
                    end else if (!hi_sent) begin
                        mem_req.valid <= 1'b1;
                        mem_req.addr  <= next_line;
                        hi_sent       <= 1'b1;
                    end else begin
                        // second fill lands on this edge
                        state <= dcache_pkg::READ_OUT;
                    end
                end
                dcache_pkg::READ_OUT: begin
                    cpu_resp.done  <= 1'b1;
                    cpu_resp.rdata <= load_data;
                    state          <= dcache_pkg::IDLE;
                end
                dcache_pkg::STORE_WAIT: begin
                    if (mem_resp.done) begin
                        mem_req.valid  <= 1'b0;
                        cpu_resp.done  <= 1'b1;
                        cpu_resp.rdata <= '0;
                        state          <= dcache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
// data cache top level
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire dcache_pkg::cpu_req_t   cpu_req,
    output logic                        cpu_ready,
    output dcache_pkg::cpu_resp_t       cpu_resp,
    output dcache_pkg::mem_req_t        mem_req,
    input  wire dcache_pkg::mem_resp_t  mem_resp
);

    wire dcache_pkg::addr_t       lookup_addr;
    wire dcache_pkg::size_e       size;
    wire logic                    hit;
    wire dcache_pkg::word_t       line_lo;
    wire dcache_pkg::word_t       line_hi;
    wire logic                    fill_en;
    wire dcache_pkg::addr_t       fill_addr;
    wire dcache_pkg::word_t       fill_data;
    wire logic                    store_en;
    wire dcache_pkg::word_t       load_data;
    wire dcache_pkg::word_t [1:0] store_bytes;
    wire dcache_pkg::be_t         store_mask;

    dcache_ctrl ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_ready   (cpu_ready),
        .cpu_resp    (cpu_resp),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp),
        .hit         (hit),
        .load_data   (load_data),
        .store_bytes (store_bytes),
        .lookup_addr (lookup_addr),
        .size        (size),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .store_en    (store_en)
    );

    dcache_storage storage0 (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .size        (size),
        .hit         (hit),
        .line_lo     (line_lo),
        .line_hi     (line_hi),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .store_en    (store_en),
        .store_bytes (store_bytes),
        .store_mask  (store_mask)
    );

    // store value taken straight from the bus, only used on acceptance
    dcache_align align0 (
        .offset      (lookup_addr[`DC_OFFSET_W-1:0]),
        .size        (size),
        .line_lo     (line_lo),
        .line_hi     (line_hi),
        .load_data   (load_data),
        .store_value (cpu_req.wdata),
        .store_bytes (store_bytes),
        .store_mask  (store_mask)
    );

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
// memory model with random latency
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'd95868
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t      mem_resp
);

    logic [7:0]        mem [0:(1 << `DC_ADDR_W)-1];
    logic [31:0]       rng_state;
    logic              pending;
    logic [2:0]        wait_left;
    dcache_pkg::addr_t byte_addr;
    logic [31:0]       hash;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // every address bit reaches the top byte of the product
    initial begin
        for (int a = 0; a < (1 << `DC_ADDR_W); a++) begin
            hash   = 32'(a) * 32'h9e3779b1;
            mem[a] = hash[31:24] ^ hash[15:8];
        end
        mem_resp  = '0;
        pending   = 1'b0;
        wait_left = '0;
        rng_state = SEED;
    end

    always @(posedge clk) begin
        if (reset) begin
            mem_resp <= '0;
            pending  <= 1'b0;
        end else begin
            mem_resp.done <= 1'b0;
            if (pending) begin
                if (wait_left == 3'd1) begin
                    pending       <= 1'b0;
                    mem_resp.done <= 1'b1;
                    if (mem_req.write) begin
                        mem_resp.rdata <= '0;
                        // bytes leave wdata from the top, lowest address first
                        for (int i = 0; i < (1 << mem_req.size); i++) begin
                            byte_addr      = mem_req.addr + dcache_pkg::addr_t'(i);
                            mem[byte_addr] <= mem_req.wdata[31-8*i -: 8];
                        end
                    end else begin
                        byte_addr      = {mem_req.addr[`DC_ADDR_W-1:2], 2'b00};
                        mem_resp.rdata <= {mem[byte_addr], mem[byte_addr + 1],
                                           mem[byte_addr + 2], mem[byte_addr + 3]};
                    end
                end else begin
                    wait_left <= wait_left - 3'd1;
                end
            end else if (mem_req.valid && !mem_resp.done) begin
                // 1 to 4 cycles until done
                pending   <= 1'b1;
                wait_left <= {1'b0, rng_state[1:0]} + 3'd1;
                rng_state <= xorshift(rng_state);
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
// data cache testbench
`timescale 1ns/10ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache;

    typedef logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] line_num_t;

    localparam real CLK_PERIOD   = 4.0;
    localparam real DRIVE_DELAY  = 0.5;
    localparam int  RESET_CYCLES = 10;
    localparam int  NUM_ACCESSES = 40;
    // slowest miss plus the gap between accesses
    localparam int  WORST_CYCLES = 24;
    localparam dcache_pkg::addr_t NOISE_ADDR = 17'h07100;

    logic                  clk = 1'b0;
    logic                  reset;
    dcache_pkg::cpu_req_t  cpu_req;
    logic                  cpu_ready;
    dcache_pkg::cpu_resp_t cpu_resp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;

    logic [7:0] shadow [0:(1 << `DC_ADDR_W)-1];
    logic       line_valid [`DC_LINES];
    line_num_t  line_held [`DC_LINES];
    int         read_count = 0;
    int         write_count = 0;
    int         done_count = 0;
    int         access_count = 0;

    dcache_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_resp  (cpu_resp),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    tb_mem_model #(.SEED(32'd95868)) mem0 (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    always #(CLK_PERIOD / 2.0) clk = ~clk;

    // counted on the edge that ends each transfer
    always @(posedge clk) begin
        if (!reset) begin
            if (mem_req.valid && mem_resp.done) begin
                if (mem_req.write) begin
                    write_count++;
                end else begin
                    read_count++;
                end
            end
            if (cpu_resp.done) begin
                done_count++;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_ACCESSES * WORST_CYCLES));
        $display("watchdog expired: the accesses did not complete in time");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic int size_bytes(input dcache_pkg::size_e size);
        return (size == dcache_pkg::SIZE_BYTE) ? 1 : (size == dcache_pkg::SIZE_HALF) ? 2 : 4;
    endfunction

    // lowest address is the least significant byte, sign from the top one
    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::addr_t addr,
                                                        input dcache_pkg::size_e size);
        dcache_pkg::word_t v;
        v = '0;
        for (int i = 0; i < size_bytes(size); i++) begin
            v[8*i +: 8] = shadow[addr + dcache_pkg::addr_t'(i)];
        end
        if (size == dcache_pkg::SIZE_BYTE) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (size == dcache_pkg::SIZE_HALF) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    function automatic logic line_cached(input line_num_t ln);
        return line_valid[ln[`DC_INDEX_W-1:0]] && (line_held[ln[`DC_INDEX_W-1:0]] == ln);
    endfunction

    function automatic logic access_cached(input dcache_pkg::addr_t addr,
                                           input dcache_pkg::size_e size);
        dcache_pkg::addr_t last;
        last = addr + dcache_pkg::addr_t'(size_bytes(size) - 1);
        return line_cached(addr[`DC_ADDR_W-1:2]) && line_cached(last[`DC_ADDR_W-1:2]);
    endfunction

    // a miss brings in the addressed line and the one after it
    function automatic void record_fill(input dcache_pkg::addr_t addr);
        line_num_t ln;
        ln = addr[`DC_ADDR_W-1:2];
        for (int i = 0; i < 2; i++) begin
            line_valid[ln[`DC_INDEX_W-1:0]] = 1'b1;
            line_held[ln[`DC_INDEX_W-1:0]]  = ln;
            ln = ln + 1'b1;
        end
    endfunction

    task automatic run_access(input dcache_pkg::op_e op, input dcache_pkg::size_e size,
                              input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata,
                              input logic noise, output dcache_pkg::word_t rdata,
                              output int latency);
        @(posedge clk);
        #(DRIVE_DELAY);
        cpu_req = '{valid: 1'b1, op: op, size: size, addr: addr, wdata: wdata};
        while (!cpu_ready) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        latency = 1;
        // a second request held while busy must be dropped
        if (noise) begin
            cpu_req = '{valid: 1'b1, op: dcache_pkg::OP_STORE, size: dcache_pkg::SIZE_WORD,
                        addr: NOISE_ADDR, wdata: 32'hdeadbeef};
        end else begin
            cpu_req.valid = 1'b0;
        end
        check_value("cpu_ready", cpu_ready, 0);
        while (!cpu_resp.done) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            latency++;
            check_value("cpu_ready", cpu_ready, 0);
        end
        rdata = cpu_resp.rdata;
        // held request also spans the done cycle
        if (noise) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_value("cpu_ready", cpu_ready, 1);
        end
        cpu_req.valid = 1'b0;
        access_count++;
    endtask

    task automatic load_and_check(input dcache_pkg::size_e size, input dcache_pkg::addr_t addr,
                                  input logic noise);
        dcache_pkg::word_t rdata;
        dcache_pkg::word_t expected;
        int                latency;
        int                reads_before;
        int                writes_before;
        logic              was_cached;
        was_cached    = access_cached(addr, size);
        expected      = expected_load(addr, size);
        reads_before  = read_count;
        writes_before = write_count;
        run_access(dcache_pkg::OP_LOAD, size, addr, '0, noise, rdata, latency);
        check_value($sformatf("cpu_resp.rdata at %h", addr), rdata, expected);
        check_value("mem writes on load", write_count - writes_before, 0);
        if (was_cached) begin
            check_value($sformatf("mem reads on hit at %h", addr), read_count - reads_before, 0);
            check_value("hit latency", latency, 1);
        end else begin
            check_value($sformatf("mem reads on miss at %h", addr), read_count - reads_before, 2);
            record_fill(addr);
        end
    endtask

    task automatic store_and_check(input dcache_pkg::size_e size, input dcache_pkg::addr_t addr,
                                   input dcache_pkg::word_t wdata);
        dcache_pkg::word_t rdata;
        dcache_pkg::addr_t a;
        int                latency;
        int                reads_before;
        int                writes_before;
        reads_before  = read_count;
        writes_before = write_count;
        run_access(dcache_pkg::OP_STORE, size, addr, wdata, 1'b0, rdata, latency);
        check_value("cpu_resp.rdata on store", rdata, 0);
        check_value("mem reads on store", read_count - reads_before, 0);
        check_value("mem writes on store", write_count - writes_before, 1);
        for (int i = 0; i < size_bytes(size); i++) begin
            a         = addr + dcache_pkg::addr_t'(i);
            shadow[a] = wdata[8*i +: 8];
            check_value($sformatf("memory byte %h", a), mem0.mem[a], shadow[a]);
        end
    endtask

    task automatic word_miss_then_hit();
        load_and_check(dcache_pkg::SIZE_WORD, 17'h01230, 1'b0);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h01230, 1'b0);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h01231, 1'b0);
    endtask

    task automatic byte_half_offsets();
        load_and_check(dcache_pkg::SIZE_WORD, 17'h02040, 1'b0);
        store_and_check(dcache_pkg::SIZE_WORD, 17'h02040, 32'h80ff7f01);
        store_and_check(dcache_pkg::SIZE_BYTE, 17'h02044, 32'h000000c3);
        for (int off = 0; off < 4; off++) begin
            load_and_check(dcache_pkg::SIZE_BYTE, 17'h02040 + 17'(off), 1'b0);
            load_and_check(dcache_pkg::SIZE_HALF, 17'h02040 + 17'(off), 1'b0);
        end
    endtask

    task automatic store_hit_updates();
        load_and_check(dcache_pkg::SIZE_WORD, 17'h04100, 1'b0);
        store_and_check(dcache_pkg::SIZE_HALF, 17'h04102, 32'h0000beef);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h04100, 1'b0);
        store_and_check(dcache_pkg::SIZE_WORD, 17'h04102, 32'h13579bdf);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h04102, 1'b0);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h04104, 1'b0);
    endtask

    task automatic store_miss_no_allocate();
        store_and_check(dcache_pkg::SIZE_WORD, 17'h05200, 32'h0badcafe);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h05200, 1'b0);
        // first byte hits, second falls in an absent line
        store_and_check(dcache_pkg::SIZE_HALF, 17'h05207, 32'h00004411);
        load_and_check(dcache_pkg::SIZE_HALF, 17'h05207, 1'b0);
    endtask

    task automatic line_wrap_next_tag();
        load_and_check(dcache_pkg::SIZE_WORD, 17'h06000, 1'b0);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h0603e, 1'b0);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h0603e, 1'b0);
        load_and_check(dcache_pkg::SIZE_HALF, 17'h0603f, 1'b0);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h06000, 1'b0);
        store_and_check(dcache_pkg::SIZE_WORD, 17'h0603e, 32'h24681357);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h0603e, 1'b0);
    endtask

    task automatic busy_requests_ignored();
        load_and_check(dcache_pkg::SIZE_WORD, 17'h07010, 1'b1);
        load_and_check(dcache_pkg::SIZE_WORD, 17'h07010, 1'b1);
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        for (int i = 0; i < 4; i++) begin
            check_value("memory byte under ignored store", mem0.mem[NOISE_ADDR + 17'(i)],
                        shadow[NOISE_ADDR + 17'(i)]);
        end
        check_value("cpu_resp.done pulses", done_count, access_count);
    endtask

    initial begin
        reset   = 1'b1;
        cpu_req = '0;
        for (int i = 0; i < `DC_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_held[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        for (int a = 0; a < (1 << `DC_ADDR_W); a++) begin
            shadow[a] = mem0.mem[a];
        end
        #(DRIVE_DELAY);
        reset = 1'b0;
        word_miss_then_hit();
        byte_half_offsets();
        store_hit_updates();
        store_miss_no_allocate();
        line_wrap_next_tag();
        busy_requests_ignored();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_storage.sv
verilog/dcache_align.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_storage.sv
      - verilog/dcache_align.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_mem_model.sv
      - tests/tb_dcache.sv
